//--- verif/program_stim.txt
// word 0 is the program length in words, then the program words from address 0
// expected records: 1 pc rd data = writeback, 2 addr data = store
// 3 n = end of section n, 0 = end of the list
00000031
34011234 3c028000 340300ff 34040f0f 00232821 00613023 00243824 00244025
0041482a 0022502a 00210021 340b0005 016b6021 018b6821 01ab7023 018e7821
34100040 ae0ffffc 8e12fffc 02509821 ae130004 34140003 128b0002 34150011
34160022 34170005 12eb0002 02f7c021 3419dead 17000002 34190077 341a0bad
16940002 341a0026 341b0027 8e1c0004 13930002 341d0029 341dffff 0c00002c
341e0030 34010001 34010002 34010003 03e01021 08000030 34030033 34030044
ae020008
1 00000000 01 00001234   1 00000004 02 80000000
1 00000008 03 000000ff   1 0000000c 04 00000f0f
1 00000010 05 00001333   1 00000014 06 ffffeecb
1 00000018 07 00000204   1 0000001c 08 00001f3f
1 00000020 09 00000001   1 00000024 0a 00000000
3 1
1 0000002c 0b 00000005   1 00000030 0c 0000000a
1 00000034 0d 0000000f   1 00000038 0e 0000000a
1 0000003c 0f 00000014
3 2
1 00000040 10 00000040   2 0000003c 00000014
1 00000048 12 00000014   1 0000004c 13 00000054
2 00000044 00000054
3 3
1 00000054 14 00000003   1 0000005c 15 00000011
1 00000060 16 00000022   1 00000064 17 00000005
1 0000006c 18 0000000a   1 00000078 19 00000077
1 00000084 1a 00000026   1 00000088 1b 00000027
1 0000008c 1c 00000054   1 00000094 1d 00000029
3 4
1 0000009c 1f 000000a4   1 000000a0 1e 00000030
1 000000b0 02 000000a4   1 000000b8 03 00000033
2 00000048 000000a4
3 5
0

//--- files.f
common/mips_pkg.sv
source/alu.sv
source/reg_file.sv
source/data_mem.sv
source/decode_unit.sv
source/hazard_unit.sv
source/mips_core.sv
source/mips_sys.sv
verif/tb_mips_sys.sv

//--- Makefile
TB_TOP = tb_mips_sys

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -Wall \
		-f files.f --top-module mips_sys

sim:
	verilator --binary --timing --timescale 1ns/1ps -j 0 \
		-f files.f --top-module $(TB_TOP)
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q "^NO ERRORS$$" sim.log

clean:
	rm -rf obj_dir sim.log

//--- verif/tb_mips_sys.sv
`default_nettype none

module tb_mips_sys;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int stim_words = 256;
	localparam int prog_max = 128;                  // fetch index is instr_addr[8:2]
	localparam int drain_cycles = 8;

	logic clk;
	logic rst_n;
	logic [mips_pkg::xlen-1:0] instr;
	logic [mips_pkg::xlen-1:0] instr_addr;
	mips_pkg::wb_trace_t wb_trace;
	mips_pkg::mem_req_t store_trace;

	logic [31:0] stim [stim_words];
	logic [mips_pkg::xlen-1:0] prog [prog_max];
	mips_pkg::wb_trace_t wb_q [$];
	mips_pkg::mem_req_t store_q [$];
	int prog_len;
	int exp_ptr;                                    // next expected record in stim
	int cycle_count;
	int cycle_limit;
	int check_count;
	int error_count;
	int section_checks;
	int section_errors;
	logic list_done;

	mips_sys mips_sys_inst (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.instr_addr(instr_addr),
		.wb_trace(wb_trace),
		.store_trace(store_trace)
	);

	always #10 clk = ~clk;

	// ====================================================================
	// compare and record matching
	// ====================================================================
	task automatic check_wb(input mips_pkg::wb_trace_t got, input mips_pkg::wb_trace_t want);
		check_count++;
		section_checks++;
		if ({got.pc, got.rd, got.data} !== {want.pc, want.rd, want.data}) begin
			$display("error %0d ns: writeback pc %h r%0d = %h, expected pc %h r%0d = %h",
				$time, got.pc, got.rd, got.data, want.pc, want.rd, want.data);
			error_count++;
			section_errors++;
		end
	endtask

	task automatic check_store(input mips_pkg::mem_req_t got, input mips_pkg::mem_req_t want);
		check_count++;
		section_checks++;
		if ({got.addr, got.wdata} !== {want.addr, want.wdata}) begin
			$display("error %0d ns: store addr %h data %h, expected addr %h data %h",
				$time, got.addr, got.wdata, want.addr, want.wdata);
			error_count++;
			section_errors++;
		end
	endtask

	task automatic report_extra(input string what);
		$display("unexpected %s at %0d ns, not the next record in the expected list",
			what, $time);
		error_count++;
		section_errors++;
	endtask

	// a section ends once all of its records have been seen
	task automatic close_sections();
		while (stim[exp_ptr] === 32'd3) begin
			$display("section %0d: %0d checks, %0d errors", stim[exp_ptr+1],
				section_checks, section_errors);
			section_checks = 0;
			section_errors = 0;
			exp_ptr += 2;
		end
		if (stim[exp_ptr] === 32'd0) list_done = 1'b1;
	endtask

	task automatic take_wb(input mips_pkg::wb_trace_t got);
		mips_pkg::wb_trace_t want;
		if (stim[exp_ptr] !== 32'd1) begin
			report_extra($sformatf("writeback (pc %h r%0d)", got.pc, got.rd));
			return;
		end
		want.pc = stim[exp_ptr+1];
		want.rd = stim[exp_ptr+2][4:0];
		want.data = stim[exp_ptr+3];
		check_wb(got, want);
		exp_ptr += 4;
		close_sections();
	endtask

	task automatic take_store(input mips_pkg::mem_req_t got);
		mips_pkg::mem_req_t want;
		if (stim[exp_ptr] !== 32'd2) begin
			report_extra($sformatf("store (addr %h data %h)", got.addr, got.wdata));
			return;
		end
		want.addr = stim[exp_ptr+1];
		want.wdata = stim[exp_ptr+2];
		check_store(got, want);
		exp_ptr += 3;
		close_sections();
	endtask

	// ====================================================================
	// fetch port and trace collection
	// ====================================================================
	always @(negedge clk) begin
		if (instr_addr < 4 * prog_max) instr = prog[instr_addr[8:2]];
		else instr = '0;                            // nop outside the program
		if (rst_n) begin
			if (wb_trace.valid === 1'b1) wb_q.push_back(wb_trace);
			if (store_trace.we === 1'b1) store_q.push_back(store_trace);
			while (wb_q.size() > 0) take_wb(wb_q.pop_front());   // older instruction first
			while (store_q.size() > 0) take_store(store_q.pop_front());
		end
	end

	initial begin
		clk = 1'b0;
		rst_n = 1'b0;
		instr = '0;
		cycle_count = 0;
		check_count = 0;
		error_count = 0;
		section_checks = 0;
		section_errors = 0;
		list_done = 1'b0;
		$readmemh("verif/program_stim.txt", stim);
		prog_len = stim[0];
		for (int i = 0; i < prog_max; i++) begin
			prog[i] = (i < prog_len) ? stim[i+1] : '0;
		end
		exp_ptr = prog_len + 1;
		cycle_limit = 3 * prog_len + 20;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst_n = 1'b1;
		while (!list_done && cycle_count < cycle_limit) begin
			@(posedge clk);
			cycle_count++;
		end
		if (list_done) begin
			repeat (drain_cycles) @(posedge clk);   // catch records past the end
		end else begin
			$display("timeout after %0d cycles, expected records missing from stim word %0d",
				cycle_count, exp_ptr);
			error_count++;
		end
		$display("%0d checks, %0d errors", check_count, error_count);
		if (error_count == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- source/mips_sys.sv
`default_nettype none

module mips_sys (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [mips_pkg::xlen-1:0] instr,
	output logic [mips_pkg::xlen-1:0] instr_addr,
	output mips_pkg::wb_trace_t wb_trace,
	output mips_pkg::mem_req_t store_trace
);

	mips_pkg::mem_req_t mem_req;
	logic [mips_pkg::xlen-1:0] mem_rdata;

	mips_core mips_core_inst (
		.clk(clk),
		.rst_n(rst_n),
		.instr(instr),
		.mem_rdata(mem_rdata),
		.instr_addr(instr_addr),
		.mem_req(mem_req),
		.wb_trace(wb_trace)
	);

	data_mem data_mem_inst (
		.clk(clk),
		.req(mem_req),
		.rdata(mem_rdata)
	);

	assign store_trace = mem_req;                   // we marks a store

endmodule

`default_nettype wire

//--- source/mips_core.sv
`default_nettype none

module mips_core (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [mips_pkg::xlen-1:0] instr,
	input wire logic [mips_pkg::xlen-1:0] mem_rdata,
	output logic [mips_pkg::xlen-1:0] instr_addr,
	output mips_pkg::mem_req_t mem_req,
	output mips_pkg::wb_trace_t wb_trace
);

	// ==================================================================
	// declarations
	// ==================================================================
	logic [mips_pkg::xlen-1:0] pc, pc_next;
	logic [mips_pkg::xlen-1:0] if_id_instr, if_id_pc;
	mips_pkg::id_ex_t id_ex;
	mips_pkg::ex_mem_t ex_mem;
	mips_pkg::mem_wb_t mem_wb;

	mips_pkg::ctrl_t id_ctrl;
	logic [mips_pkg::xlen-1:0] rd1, rd2;
	logic [mips_pkg::xlen-1:0] id_rs_val, id_rt_val, id_imm;
	logic [mips_pkg::xlen-1:0] slot_pc, br_target, jump_target;

	logic stall;
	mips_pkg::fwd_e fwd_id_rs, fwd_id_rt, fwd_ex_rs, fwd_ex_rt;

	logic [mips_pkg::xlen-1:0] ex_rs_val, ex_rt_val, alu_b, alu_y;
	logic [mips_pkg::xlen-1:0] ex_link, mem_link, wb_link;
	logic [mips_pkg::xlen-1:0] wb_data;
	logic wb_we;

	function automatic logic [mips_pkg::xlen-1:0] fwd_mux(
		input mips_pkg::fwd_e sel,
		input logic [mips_pkg::xlen-1:0] base,
		input logic [mips_pkg::xlen-1:0] e_link,
		input logic [mips_pkg::xlen-1:0] m_alu,
		input logic [mips_pkg::xlen-1:0] m_link,
		input logic [mips_pkg::xlen-1:0] w_data
	);
		case (sel)
			mips_pkg::fwd_ex_link: return e_link;
			mips_pkg::fwd_mem_alu: return m_alu;
			mips_pkg::fwd_mem_link: return m_link;
			mips_pkg::fwd_wb: return w_data;
			default: return base;
		endcase
	endfunction

	assign ex_link = id_ex.pc + 32'd8;
	assign mem_link = ex_mem.pc + 32'd8;
	assign wb_link = mem_wb.pc + 32'd8;

	// ==================================================================
	// fetch
	// ==================================================================
	assign instr_addr = pc;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			pc <= '0;
			if_id_instr <= '0;              // word 0 decodes as a bubble
			if_id_pc <= '0;
		end else if (!stall) begin
			pc <= pc_next;
			if_id_instr <= instr;
			if_id_pc <= pc;
		end
	end

	// ==================================================================
	// decode and branch resolution
	// ==================================================================
	decode_unit decode_unit_inst (
		.instr(if_id_instr),
		.ctrl(id_ctrl)
	);

	reg_file reg_file_inst (
		.clk(clk),
		.rst_n(rst_n),
		.ra1(id_ctrl.rs),
		.ra2(id_ctrl.rt),
		.wa(mem_wb.ctrl.dst),
		.we(wb_we),
		.wd(wb_data),
		.rd1(rd1),
		.rd2(rd2)
	);

	hazard_unit hazard_unit_inst (
		.id_ctrl(id_ctrl),
		.ex(id_ex),
		.mem(ex_mem),
		.wb(mem_wb),
		.stall(stall),
		.fwd_id_rs(fwd_id_rs),
		.fwd_id_rt(fwd_id_rt),
		.fwd_ex_rs(fwd_ex_rs),
		.fwd_ex_rt(fwd_ex_rt)
	);

	assign id_rs_val = fwd_mux(fwd_id_rs, rd1, ex_link, ex_mem.alu_y, mem_link, wb_data);
	assign id_rt_val = fwd_mux(fwd_id_rt, rd2, ex_link, ex_mem.alu_y, mem_link, wb_data);

	assign id_imm = id_ctrl.imm_zext ? {16'h0, if_id_instr[15:0]} :
		{{16{if_id_instr[15]}}, if_id_instr[15:0]};

	assign slot_pc = if_id_pc + 32'd4;              // delay slot address
	assign br_target = slot_pc + {{14{if_id_instr[15]}}, if_id_instr[15:0], 2'b00};
	assign jump_target = {slot_pc[31:28], if_id_instr[25:0], 2'b00};

	always_comb begin
		pc_next = pc + 32'd4;
		case (id_ctrl.instr)
			mips_pkg::i_beq: if (id_rs_val == id_rt_val) pc_next = br_target;
			mips_pkg::i_bne: if (id_rs_val != id_rt_val) pc_next = br_target;
			mips_pkg::i_j, mips_pkg::i_jal: pc_next = jump_target;
			default: pc_next = pc + 32'd4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			id_ex.ctrl <= mips_pkg::ctrl_bubble;
		end else begin
			id_ex <= '{
				pc: if_id_pc,
				ctrl: stall ? mips_pkg::ctrl_bubble : id_ctrl,    // bubble on stall
				rs_val: id_rs_val,
				rt_val: id_rt_val,
				imm: id_imm
			};
		end
	end

	// ==================================================================
	// execute
	// ==================================================================
	assign ex_rs_val = fwd_mux(fwd_ex_rs, id_ex.rs_val, ex_link, ex_mem.alu_y, mem_link,
		wb_data);
	assign ex_rt_val = fwd_mux(fwd_ex_rt, id_ex.rt_val, ex_link, ex_mem.alu_y, mem_link,
		wb_data);
	assign alu_b = id_ex.ctrl.use_imm ? id_ex.imm : ex_rt_val;

	alu alu_inst (
		.op(id_ex.ctrl.alu_op),
		.a(ex_rs_val),
		.b(alu_b),
		.y(alu_y)
	);

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_mem.ctrl <= mips_pkg::ctrl_bubble;
		end else begin
			ex_mem <= '{pc: id_ex.pc, ctrl: id_ex.ctrl, alu_y: alu_y, st_data: ex_rt_val};
		end
	end

	// ==================================================================
	// memory and write-back
	// ==================================================================
	assign mem_req = '{addr: ex_mem.alu_y, wdata: ex_mem.st_data, we: ex_mem.ctrl.mem_write};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			mem_wb.ctrl <= mips_pkg::ctrl_bubble;
		end else begin
			mem_wb <= '{pc: ex_mem.pc, ctrl: ex_mem.ctrl, alu_y: ex_mem.alu_y,
				ld_data: mem_rdata};
		end
	end

	always_comb begin
		case (mem_wb.ctrl.wb_sel)
			mips_pkg::wb_alu: wb_data = mem_wb.alu_y;
			mips_pkg::wb_mem: wb_data = mem_wb.ld_data;
			mips_pkg::wb_link: wb_data = wb_link;       // pc + 8 of the jal
			default: wb_data = '0;
		endcase
	end

	assign wb_we = (mem_wb.ctrl.wb_sel != mips_pkg::wb_none) && (mem_wb.ctrl.dst != '0);
	assign wb_trace = '{valid: wb_we, pc: mem_wb.pc, rd: mem_wb.ctrl.dst, data: wb_data};

endmodule

`default_nettype wire

//--- source/hazard_unit.sv
`default_nettype none

module hazard_unit (
	input wire mips_pkg::ctrl_t id_ctrl,
	input wire mips_pkg::id_ex_t ex,
	input wire mips_pkg::ex_mem_t mem,
	input wire mips_pkg::mem_wb_t wb,
	output logic stall,
	output mips_pkg::fwd_e fwd_id_rs,
	output mips_pkg::fwd_e fwd_id_rt,
	output mips_pkg::fwd_e fwd_ex_rs,
	output mips_pkg::fwd_e fwd_ex_rt
);

	logic id_branch;

	// stage c will write register r
	function automatic logic hits(input logic [mips_pkg::reg_addr_w-1:0] r,
		input mips_pkg::ctrl_t c);
		return (r != '0) && (c.wb_sel != mips_pkg::wb_none) && (c.dst == r);
	endfunction

	// youngest producer wins; an unready one leaves the register file value
	function automatic mips_pkg::fwd_e id_sel(input logic [mips_pkg::reg_addr_w-1:0] r,
		input mips_pkg::ctrl_t e_c, input mips_pkg::ctrl_t m_c, input mips_pkg::ctrl_t w_c);
		if (hits(r, e_c))
			return (e_c.wb_sel == mips_pkg::wb_link) ? mips_pkg::fwd_ex_link : mips_pkg::fwd_rf;
		if (hits(r, m_c)) begin
			if (m_c.wb_sel == mips_pkg::wb_alu) return mips_pkg::fwd_mem_alu;
			if (m_c.wb_sel == mips_pkg::wb_link) return mips_pkg::fwd_mem_link;
			return mips_pkg::fwd_rf;                // load in memory, fixed in execute
		end
		if (hits(r, w_c)) return mips_pkg::fwd_wb;
		return mips_pkg::fwd_rf;
	endfunction

	function automatic mips_pkg::fwd_e ex_sel(input logic [mips_pkg::reg_addr_w-1:0] r,
		input mips_pkg::ctrl_t m_c, input mips_pkg::ctrl_t w_c);
		if (hits(r, m_c))
			return (m_c.wb_sel == mips_pkg::wb_link) ? mips_pkg::fwd_mem_link :
				mips_pkg::fwd_mem_alu;
		if (hits(r, w_c)) return mips_pkg::fwd_wb;
		return mips_pkg::fwd_rf;
	endfunction

	function automatic logic needs_stall(input logic [mips_pkg::reg_addr_w-1:0] r,
		input logic branch, input mips_pkg::ctrl_t e_c, input mips_pkg::ctrl_t m_c);
		if (hits(r, e_c))
			return e_c.mem_read || (branch && (e_c.wb_sel != mips_pkg::wb_link));
		if (hits(r, m_c)) return branch && m_c.mem_read;
		return 1'b0;
	endfunction

	assign id_branch = (id_ctrl.instr == mips_pkg::i_beq) || (id_ctrl.instr == mips_pkg::i_bne);

	assign fwd_id_rs = id_sel(id_ctrl.rs, ex.ctrl, mem.ctrl, wb.ctrl);
	assign fwd_id_rt = id_sel(id_ctrl.rt, ex.ctrl, mem.ctrl, wb.ctrl);
	assign fwd_ex_rs = ex_sel(ex.ctrl.rs, mem.ctrl, wb.ctrl);
	assign fwd_ex_rt = ex_sel(ex.ctrl.rt, mem.ctrl, wb.ctrl);

	assign stall = needs_stall(id_ctrl.rs, id_branch, ex.ctrl, mem.ctrl) ||
		needs_stall(id_ctrl.rt, id_branch, ex.ctrl, mem.ctrl);

endmodule

`default_nettype wire

//--- source/decode_unit.sv
`default_nettype none

module decode_unit (
	input wire logic [mips_pkg::xlen-1:0] instr,
	output mips_pkg::ctrl_t ctrl
);

	typedef enum logic [5:0] {
		op_special = 6'h00, op_j = 6'h02, op_jal = 6'h03, op_beq = 6'h04,
		op_bne = 6'h05, op_ori = 6'h0d, op_lui = 6'h0f, op_lw = 6'h23, op_sw = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		fn_addu = 6'h21, fn_subu = 6'h23, fn_and = 6'h24, fn_or = 6'h25, fn_slt = 6'h2a
	} funct_e;

	opcode_e opcode;
	funct_e funct;
	logic [mips_pkg::reg_addr_w-1:0] rs_f, rt_f, rd_f;

	assign opcode = opcode_e'(instr[31:26]);
	assign funct = funct_e'(instr[5:0]);
	assign rs_f = instr[25:21];
	assign rt_f = instr[20:16];
	assign rd_f = instr[15:11];

	always_comb begin
		ctrl = mips_pkg::ctrl_bubble;               // unsupported words stay a bubble
		case (opcode)
			op_special: begin
				ctrl.rs = rs_f;
				ctrl.rt = rt_f;
				ctrl.dst = rd_f;
				ctrl.wb_sel = mips_pkg::wb_alu;
				case (funct)
					fn_addu: ctrl.instr = mips_pkg::i_addu;
					fn_subu: begin
						ctrl.instr = mips_pkg::i_subu;
						ctrl.alu_op = mips_pkg::alu_sub;
					end
					fn_and: begin
						ctrl.instr = mips_pkg::i_and;
						ctrl.alu_op = mips_pkg::alu_and;
					end
					fn_or: begin
						ctrl.instr = mips_pkg::i_or;
						ctrl.alu_op = mips_pkg::alu_or;
					end
					fn_slt: begin
						ctrl.instr = mips_pkg::i_slt;
						ctrl.alu_op = mips_pkg::alu_slt;
					end
					default: ctrl = mips_pkg::ctrl_bubble;
				endcase
			end
			op_ori, op_lui: begin
				ctrl.instr = (opcode == op_ori) ? mips_pkg::i_ori : mips_pkg::i_lui;
				ctrl.alu_op = (opcode == op_ori) ? mips_pkg::alu_or : mips_pkg::alu_lui;
				ctrl.use_imm = 1'b1;
				ctrl.imm_zext = 1'b1;
				ctrl.rs = (opcode == op_ori) ? rs_f : '0;   // lui reads no register
				ctrl.dst = rt_f;
				ctrl.wb_sel = mips_pkg::wb_alu;
			end
			op_lw: begin
				ctrl.instr = mips_pkg::i_lw;
				ctrl.use_imm = 1'b1;
				ctrl.rs = rs_f;
				ctrl.dst = rt_f;
				ctrl.wb_sel = mips_pkg::wb_mem;
				ctrl.mem_read = 1'b1;
			end
			op_sw: begin
				ctrl.instr = mips_pkg::i_sw;
				ctrl.use_imm = 1'b1;
				ctrl.rs = rs_f;
				ctrl.rt = rt_f;                     // store data
				ctrl.mem_write = 1'b1;
			end
			op_beq, op_bne: begin
				ctrl.instr = (opcode == op_beq) ? mips_pkg::i_beq : mips_pkg::i_bne;
				ctrl.rs = rs_f;
				ctrl.rt = rt_f;
			end
			op_j: ctrl.instr = mips_pkg::i_j;
			op_jal: begin
				ctrl.instr = mips_pkg::i_jal;
				ctrl.dst = mips_pkg::ra_reg;
				ctrl.wb_sel = mips_pkg::wb_link;
			end
			default: ctrl = mips_pkg::ctrl_bubble;
		endcase
	end

endmodule

`default_nettype wire

//--- source/data_mem.sv
`default_nettype none

module data_mem (
	input wire logic clk,
	input wire mips_pkg::mem_req_t req,
	output logic [mips_pkg::xlen-1:0] rdata
);

	logic [mips_pkg::xlen-1:0] mem [mips_pkg::dmem_words];
	logic [mips_pkg::dmem_addr_w-1:0] idx;

	assign idx = req.addr[mips_pkg::dmem_addr_w+1:2];    // drop byte offset

	always_ff @(posedge clk) begin
		if (req.we) begin
			mem[idx] <= req.wdata;
		end
	end

	assign rdata = mem[idx];                        // combinational read

endmodule

`default_nettype wire

//--- source/reg_file.sv
`default_nettype none

module reg_file (
	input wire logic clk,
	input wire logic rst_n,
	input wire logic [mips_pkg::reg_addr_w-1:0] ra1,
	input wire logic [mips_pkg::reg_addr_w-1:0] ra2,
	input wire logic [mips_pkg::reg_addr_w-1:0] wa,
	input wire logic we,
	input wire logic [mips_pkg::xlen-1:0] wd,
	output logic [mips_pkg::xlen-1:0] rd1,
	output logic [mips_pkg::xlen-1:0] rd2
);

	logic [mips_pkg::xlen-1:0] regs [2**mips_pkg::reg_addr_w];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < 2**mips_pkg::reg_addr_w; i++) regs[i] <= '0;
		end else if (we && (wa != '0)) begin
			regs[wa] <= wd;                         // r0 never written
		end
	end

	// write-through so decode sees the value retiring this cycle
	assign rd1 = (ra1 == '0) ? '0 : (we && (wa == ra1)) ? wd : regs[ra1];
	assign rd2 = (ra2 == '0) ? '0 : (we && (wa == ra2)) ? wd : regs[ra2];

endmodule

`default_nettype wire

//--- source/alu.sv
`default_nettype none

module alu (
	input wire mips_pkg::alu_op_e op,
	input wire logic [mips_pkg::xlen-1:0] a,
	input wire logic [mips_pkg::xlen-1:0] b,
	output logic [mips_pkg::xlen-1:0] y
);

	always_comb begin
		case (op)
			mips_pkg::alu_add: y = a + b;           // wraps, no trap
			mips_pkg::alu_sub: y = a - b;
			mips_pkg::alu_and: y = a & b;
			mips_pkg::alu_or: y = a | b;
			mips_pkg::alu_slt: y = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
			mips_pkg::alu_lui: y = b << 16;
			default: y = '0;
		endcase
	end

endmodule

`default_nettype wire

//--- common/mips_pkg.sv
`default_nettype none

package mips_pkg;

	// ==================================================================
	// sizes
	// ==================================================================
	localparam int xlen = 32;
	localparam int reg_addr_w = 5;
	localparam int dmem_words = 256;
	localparam int dmem_addr_w = $clog2(dmem_words);        // word index bits
	localparam logic [reg_addr_w-1:0] ra_reg = reg_addr_w'(31);   // jal link target

	// ==================================================================
	// encodings
	// ==================================================================
	typedef enum logic [3:0] {
		i_invalid, i_addu, i_subu, i_and, i_or, i_slt, i_ori,
		i_lui, i_lw, i_sw, i_beq, i_bne, i_j, i_jal
	} instr_e;

	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_or, alu_slt, alu_lui
	} alu_op_e;

	typedef enum logic [2:0] {
		fwd_rf,         // value read in decode, or as latched into execute
		fwd_ex_link,
		fwd_mem_alu,
		fwd_mem_link,
		fwd_wb
	} fwd_e;

	typedef enum logic [1:0] {wb_none, wb_alu, wb_mem, wb_link} wb_sel_e;

	// ==================================================================
	// control and stage registers
	// ==================================================================
	typedef struct packed {
		instr_e instr;
		alu_op_e alu_op;
		logic use_imm;                  // immediate replaces rt operand
		logic imm_zext;                 // zero extend instead of sign extend
		logic [reg_addr_w-1:0] rs;      // zero when not read
		logic [reg_addr_w-1:0] rt;      // zero when not read
		logic [reg_addr_w-1:0] dst;
		wb_sel_e wb_sel;
		logic mem_read;
		logic mem_write;
	} ctrl_t;

	localparam ctrl_t ctrl_bubble = '{
		instr: i_invalid,
		alu_op: alu_add,
		use_imm: 1'b0,
		imm_zext: 1'b0,
		rs: '0,
		rt: '0,
		dst: '0,
		wb_sel: wb_none,
		mem_read: 1'b0,
		mem_write: 1'b0
	};

	typedef struct packed {
		logic [xlen-1:0] pc;
		ctrl_t ctrl;
		logic [xlen-1:0] rs_val;
		logic [xlen-1:0] rt_val;
		logic [xlen-1:0] imm;
	} id_ex_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		ctrl_t ctrl;
		logic [xlen-1:0] alu_y;
		logic [xlen-1:0] st_data;
	} ex_mem_t;

	typedef struct packed {
		logic [xlen-1:0] pc;
		ctrl_t ctrl;
		logic [xlen-1:0] alu_y;
		logic [xlen-1:0] ld_data;
	} mem_wb_t;

	typedef struct packed {
		logic [xlen-1:0] addr;          // byte address
		logic [xlen-1:0] wdata;
		logic we;
	} mem_req_t;

	typedef struct packed {
		logic valid;
		logic [xlen-1:0] pc;
		logic [reg_addr_w-1:0] rd;
		logic [xlen-1:0] data;
	} wb_trace_t;

endpackage

`default_nettype wire
